// ==== logic/aluStage.sv ====
// Nine-op ALU with saved result and flags; no overflow flag, carry kept only for add, sub and shifts
module aluStage (
  input  logic            clk,
  input  logic            Reset,
  input  logic            aluSave,
  input  logic            carrySave,
  input  cpuPkg::opCodeT  op,
  input  logic            immFlag,
  input  cpuPkg::dataT    imm,
  input  cpuPkg::dataT    operandA,
  input  cpuPkg::dataT    operandB,
  output cpuPkg::dataT    aluResult,
  output logic            zFlag,
  output logic            cFlag
);

  cpuPkg::aluOpT              aluOp;
  cpuPkg::dataT               secondOp;
  logic [cpuPkg::dataWidth:0] aluWide;  // One extra bit for carry

  ////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////

  assign secondOp = immFlag ? imm : operandB;
  assign aluOp    = cpuPkg::aluOpT'(op);

  ////////////////////////////////////////
  // Operations
  ////////////////////////////////////////

  // Bit 8 carries the add carry, the subtract borrow and the bit shifted out on the left
  always_comb begin
    case (aluOp)
      cpuPkg::opAdd: begin
        aluWide = {1'b0, operandA} + {1'b0, secondOp};
      end
      cpuPkg::opSub: begin
        aluWide = {1'b0, operandA} - {1'b0, secondOp}; // Borrow when A < B
      end
      cpuPkg::opAnd: begin
        aluWide = {1'b0, operandA & secondOp};
      end
      cpuPkg::opOr: begin
        aluWide = {1'b0, operandA | secondOp};
      end
      cpuPkg::opXor: begin
        aluWide = {1'b0, operandA ^ secondOp};
      end
      cpuPkg::opShl: begin
        aluWide = {operandA, 1'b0}; // Old bit 7 lands in bit 8
      end
      cpuPkg::opShr: begin
        aluWide = {2'b00, operandA[cpuPkg::dataWidth-1:1]}; // Carry cleared
      end
      cpuPkg::opNot: begin
        aluWide = {1'b0, ~operandA};
      end
      cpuPkg::opLess: begin
        aluWide = {{cpuPkg::dataWidth{1'b0}}, (operandA < secondOp)};
      end
      default: begin
        aluWide = '0; // No-op codes, nothing gets saved
      end
    endcase
  end

  ////////////////////////////////////////
  // Result and flag registers
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      aluResult <= '0;
      zFlag     <= 1'b0;
    end else if (aluSave) begin
      aluResult <= aluWide[cpuPkg::dataWidth-1:0];
      zFlag     <= (aluWide[cpuPkg::dataWidth-1:0] == '0);
    end
  end

  // Logic ops and compare leave the carry alone
  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      cFlag <= 1'b0;
    end else if (carrySave) begin
      cFlag <= aluWide[cpuPkg::dataWidth];
    end
  end

endmodule

// ==== logic/cpuPkg.sv ====
// Shared widths and types for the 8-bit execute slice; opcodes 9 to 31 are no-ops
package cpuPkg;

  ////////////////////////////////////////
  // Widths and counts
  ////////////////////////////////////////

  localparam int dataWidth    = 8;  // Data word
  localparam int regAddrWidth = 4;  // Register index
  localparam int numRegs      = 16; // Register file depth
  localparam int opCodeWidth  = 5;  // Opcode field
  localparam int numPhases    = 5;  // T0 to T4

  ////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////

  typedef logic [dataWidth-1:0]    dataT;
  typedef logic [regAddrWidth-1:0] regAddrT;
  typedef logic [opCodeWidth-1:0]  opCodeT;

  // Three bits cover the five phases
  typedef logic [$clog2(numPhases)-1:0] phaseT;

  ////////////////////////////////////////
  // ALU opcodes
  ////////////////////////////////////////

  // Values above opLess fall through as no-ops
  typedef enum logic [opCodeWidth-1:0] {
    opAdd  = 5'd0, // A + B
    opSub  = 5'd1, // A - B
    opAnd  = 5'd2, // A & B
    opOr   = 5'd3, // A | B
    opXor  = 5'd4, // A ^ B
    opShl  = 5'd5, // A << 1
    opShr  = 5'd6, // A >> 1
    opNot  = 5'd7, // ~A
    opLess = 5'd8  // A < B, unsigned
  } aluOpT;

endpackage

// ==== logic/executeCore.sv ====
// Execute slice top; instruction fields must be stable at the end of T0 and results hold from T3
module executeCore (
  input  logic             clk,
  input  logic             Reset,
  input  cpuPkg::opCodeT   opCode,
  input  logic             immFlag,
  input  cpuPkg::regAddrT  destin,
  input  cpuPkg::regAddrT  source1,
  input  cpuPkg::regAddrT  source2,
  input  cpuPkg::dataT     imm,
  output logic             fetch,
  output cpuPkg::dataT     aluResult,
  output logic             zFlag,
  output logic             cFlag
);

  logic             regRead;
  logic             aluSave;
  logic             carrySave;
  logic             regWrite;
  cpuPkg::opCodeT   curOp;
  logic             curImmFlag;
  cpuPkg::regAddrT  curDestin;
  cpuPkg::regAddrT  curSource1;
  cpuPkg::regAddrT  curSource2;
  cpuPkg::dataT     curImm;
  cpuPkg::dataT     readData1;
  cpuPkg::dataT     readData2;

  ////////////////////////////////////////
  // Timing and control
  ////////////////////////////////////////

  phaseSequencer seq_i (
    .clk        (clk),
    .Reset      (Reset),
    .opCode     (opCode),
    .immFlag    (immFlag),
    .destin     (destin),
    .source1    (source1),
    .source2    (source2),
    .imm        (imm),
    .fetch      (fetch),
    .regRead    (regRead),
    .aluSave    (aluSave),
    .carrySave  (carrySave),
    .regWrite   (regWrite),
    .curOp      (curOp),
    .curImmFlag (curImmFlag),
    .curDestin  (curDestin),
    .curSource1 (curSource1),
    .curSource2 (curSource2),
    .curImm     (curImm)
  );

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  regFile regs_i (
    .clk       (clk),
    .Reset     (Reset),
    .regRead   (regRead),
    .regWrite  (regWrite),
    .readAddr1 (curSource1),
    .readAddr2 (curSource2),
    .writeAddr (curDestin),
    .writeData (aluResult),  // Write-back of the saved result
    .readData1 (readData1),
    .readData2 (readData2)
  );

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  aluStage alu_i (
    .clk       (clk),
    .Reset     (Reset),
    .aluSave   (aluSave),
    .carrySave (carrySave),
    .op        (curOp),
    .immFlag   (curImmFlag),
    .imm       (curImm),
    .operandA  (readData1),
    .operandB  (readData2),
    .aluResult (aluResult),
    .zFlag     (zFlag),
    .cFlag     (cFlag)
  );

endmodule

// ==== logic/phaseSequencer.sv ====
// Free-running five-phase timer with no stall input; fields are sampled only at the end of T0
module phaseSequencer (
  input  logic             clk,
  input  logic             Reset,
  input  cpuPkg::opCodeT   opCode,
  input  logic             immFlag,
  input  cpuPkg::regAddrT  destin,
  input  cpuPkg::regAddrT  source1,
  input  cpuPkg::regAddrT  source2,
  input  cpuPkg::dataT     imm,
  output logic             fetch,
  output logic             regRead,
  output logic             aluSave,
  output logic             carrySave,
  output logic             regWrite,
  output cpuPkg::opCodeT   curOp,
  output logic             curImmFlag,
  output cpuPkg::regAddrT  curDestin,
  output cpuPkg::regAddrT  curSource1,
  output cpuPkg::regAddrT  curSource2,
  output cpuPkg::dataT     curImm
);

  cpuPkg::phaseT phase;
  logic          liveOp;
  logic          carryOp;

  ////////////////////////////////////////
  // Phase counter
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      phase <= '0; // First cycle after reset is T0
    end else if (phase == cpuPkg::phaseT'(cpuPkg::numPhases - 1)) begin
      phase <= '0; // Wrap after T4
    end else begin
      phase <= phase + cpuPkg::phaseT'(1);
    end
  end

  assign fetch = (phase == cpuPkg::phaseT'(0));

  ////////////////////////////////////////
  // Instruction capture
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      curOp     <= '0;
      curDestin <= '0;
    end else if (fetch) begin
      curOp     <= opCode;
      curDestin <= destin;
    end
  end

  // Operand fields for the register reads and the ALU
  always_ff @(posedge clk) begin
    if (fetch) begin
      curImmFlag <= immFlag;
      curSource1 <= source1;
      curSource2 <= source2;
      curImm     <= imm;
    end
  end

  ////////////////////////////////////////
  // Control strobes
  ////////////////////////////////////////

  assign liveOp  = (curOp <= cpuPkg::opLess); // Opcodes 0 to 8
  assign carryOp = (curOp == cpuPkg::opAdd) || (curOp == cpuPkg::opSub) ||
                   (curOp == cpuPkg::opShl) || (curOp == cpuPkg::opShr);

  assign regRead   = (phase == cpuPkg::phaseT'(1));
  assign aluSave   = (phase == cpuPkg::phaseT'(2)) && liveOp;
  assign carrySave = (phase == cpuPkg::phaseT'(2)) && carryOp;
  assign regWrite  = (phase == cpuPkg::phaseT'(4)) && liveOp; // Write-back

endmodule

// ==== logic/regFile.sv ====
// Sixteen 8-bit registers; reads are registered, and a same-edge read and write is not used
module regFile (
  input  logic             clk,
  input  logic             Reset,
  input  logic             regRead,
  input  logic             regWrite,
  input  cpuPkg::regAddrT  readAddr1,
  input  cpuPkg::regAddrT  readAddr2,
  input  cpuPkg::regAddrT  writeAddr,
  input  cpuPkg::dataT     writeData,
  output cpuPkg::dataT     readData1,
  output cpuPkg::dataT     readData2
);

  cpuPkg::dataT regs [cpuPkg::numRegs];

  ////////////////////////////////////////
  // Storage and write port
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      for (int i = 0; i < cpuPkg::numRegs; i++) begin
        regs[i] <= '0; // All registers start at zero
      end
    end else if (regWrite) begin
      regs[writeAddr] <= writeData;
    end
  end

  ////////////////////////////////////////
  // Registered read ports
  ////////////////////////////////////////

  // Both operands are taken on the edge that ends T1 and held until the next read
  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      readData1 <= '0;
      readData2 <= '0;
    end else if (regRead) begin
      readData1 <= regs[readAddr1]; // First source
      readData2 <= regs[readAddr2]; // Second source
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the execute slice testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -f sim.f --top-module executeCoreTb -o executeCoreSim

output=$(./obj_dir/executeCoreSim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

// ==== sim.f ====
logic/cpuPkg.sv
logic/phaseSequencer.sv
logic/regFile.sv
logic/aluStage.sv
logic/executeCore.sv
sim/executeCoreTb.sv

// ==== sim/executeCoreTb.sv ====
// Reads sim/programInput.txt from the project root, one instruction per five-cycle slot
module executeCoreTb;

  logic            clk;
  logic            Reset;
  cpuPkg::opCodeT  opCode;
  logic            immFlag;
  cpuPkg::regAddrT destin;
  cpuPkg::regAddrT source1;
  cpuPkg::regAddrT source2;
  cpuPkg::dataT    imm;
  logic            fetch;
  cpuPkg::dataT    aluResult;
  logic            zFlag;
  logic            cFlag;

  // Fields of the current input line
  cpuPkg::opCodeT  stimOp;
  logic            stimImmFlag;
  cpuPkg::regAddrT stimDestin;
  cpuPkg::regAddrT stimSource1;
  cpuPkg::regAddrT stimSource2;
  cpuPkg::dataT    stimImm;
  cpuPkg::dataT    expResult;
  logic            expZ;
  logic            expC;

  int              fd;
  int              lineNum;
  int              numChecked;
  int              fields;
  string           line;

  ////////////////////////////////////////
  // DUT and clock
  ////////////////////////////////////////

  executeCore dut_i (
    .clk       (clk),
    .Reset     (Reset),
    .opCode    (opCode),
    .immFlag   (immFlag),
    .destin    (destin),
    .source1   (source1),
    .source2   (source2),
    .imm       (imm),
    .fetch     (fetch),
    .aluResult (aluResult),
    .zFlag     (zFlag),
    .cFlag     (cFlag)
  );

  always #10 clk = ~clk; // 20-unit period

  ////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkResult(input cpuPkg::dataT got, input cpuPkg::dataT expected);
    if (got !== expected) begin
      failRun($sformatf("ERROR at time %0t: aluResult is %h, expected %h (input line %0d)",
                        $time, got, expected, lineNum));
    end
  endtask

  task automatic checkFlag(input logic got, input logic expected, input string name);
    if (got !== expected) begin
      failRun($sformatf("ERROR at time %0t: %s is %b, expected %b (input line %0d)",
                        $time, name, got, expected, lineNum));
    end
  endtask

  ////////////////////////////////////////
  // Instruction sequencing
  ////////////////////////////////////////

  // Blank lines and lines that open with a slash carry no instruction
  function automatic bit isInstructionLine(input string text);
    return (text.len() > 1) && (text.getc(0) != 8'h2F);
  endfunction

  task automatic waitForFetch();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (fetch !== 1'b1) begin
      if (cycles == 20) begin
        failRun("The DUT did not raise fetch within 20 cycles");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // Called on the edge that opens T0, so the fields are stable when T0 ends
  task automatic runInstruction();
    opCode  <= stimOp;
    immFlag <= stimImmFlag;
    destin  <= stimDestin;
    source1 <= stimSource1;
    source2 <= stimSource2;
    imm     <= stimImm;
    waitForFetch();
    repeat (4) @(negedge clk); // Middle of T4
    checkResult(aluResult, expResult);
    checkFlag(zFlag, expZ, "zFlag");
    checkFlag(cFlag, expC, "cFlag");
    checkFlag(fetch, 1'b0, "fetch");
    numChecked++;
    @(posedge clk); // Opens the next T0
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    Reset      = 1'b1;
    opCode     = '0;
    immFlag    = 1'b0;
    destin     = '0;
    source1    = '0;
    source2    = '0;
    imm        = '0;
    lineNum    = 0;
    numChecked = 0;
    fd = $fopen("sim/programInput.txt", "r");
    if (fd == 0) begin
      failRun("Could not open sim/programInput.txt for reading");
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    checkResult(aluResult, '0); // Reset state
    checkFlag(zFlag, 1'b0, "zFlag");
    checkFlag(cFlag, 1'b0, "cFlag");
    checkFlag(fetch, 1'b1, "fetch");
    @(posedge clk);
    Reset <= 1'b0; // Next cycle is T0

    while ($fgets(line, fd) != 0) begin
      lineNum++;
      if (isInstructionLine(line)) begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", stimOp, stimImmFlag,
                         stimDestin, stimSource1, stimSource2, stimImm,
                         expResult, expZ, expC);
        if (fields != 9) begin
          failRun($sformatf("Line %0d of the input file does not hold nine hex fields",
                            lineNum));
        end
        runInstruction();
      end
    end
    $fclose(fd);

    if (numChecked == 0) begin
      failRun("The input file held no instructions");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// ==== sim/programInput.txt ====
// Columns, all hex: opCode immFlag destin source1 source2 imm result zFlag cFlag
// Result and flags are the values expected on the outputs during T4
// Immediate adds from r0 load the registers
00 1 1 0 0 3C 3C 0 0
00 1 2 0 0 C5 C5 0 0
00 1 3 0 0 00 00 1 0
00 1 4 0 0 F0 F0 0 0
00 1 5 0 0 81 81 0 0
// Register to register, using written-back values
00 0 6 1 2 00 01 0 1
01 0 7 2 1 00 89 0 0
01 0 8 1 2 00 77 0 1
02 0 9 2 4 00 C0 0 1
03 0 A 1 5 00 BD 0 1
04 0 B 1 1 00 00 1 1
07 0 C 4 0 00 0F 0 1
// Carry from add and subtract with immediates
01 1 D 1 0 3C 00 1 0
00 1 E 4 0 20 10 0 1
00 1 F 2 0 3B 00 1 1
// Shifts
05 0 D 5 0 00 02 0 1
06 0 E 5 0 00 40 0 0
05 0 D 1 0 00 78 0 0
00 1 9 4 0 11 01 0 1
06 0 F 6 0 00 00 1 0
// Unsigned less-than
08 0 A 1 2 00 01 0 0
00 1 8 2 0 40 05 0 1
08 1 B 2 0 C5 00 1 1
08 1 B 4 0 FF 01 0 1
// No-op codes keep result, flags and registers
09 0 1 2 4 00 01 0 1
1F 1 2 0 0 55 01 0 1
10 0 4 1 2 00 01 0 1
// Read back the no-op destinations
00 1 3 1 0 00 3C 0 0
00 1 3 2 0 00 C5 0 0
00 1 3 4 0 00 F0 0 0
// Older registers through the dual read
03 0 6 7 8 00 8D 0 0
04 0 6 A C 00 0E 0 0
01 0 6 E 9 00 3F 0 0
01 0 5 D D 00 00 1 0
